// File: hdl/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Instruction word width
`define DEC_INST_WIDTH 16

// Register file index width
`define DEC_REG_ADDR_WIDTH 4

// Datapath and literal width
`define DEC_DATA_WIDTH 32

// Special registers
`define DEC_STACK_REG 13
`define DEC_LINK_REG 14

// Byte step of the stack pointer on push and pop
`define DEC_STACK_STEP 4

`endif

// File: hdl/decode_pkg.sv
`default_nettype none
`include "decode_cfg.svh"

package decode_pkg;

  typedef logic [`DEC_INST_WIDTH-1:0]     inst_t;
  typedef logic [`DEC_REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`DEC_DATA_WIDTH-1:0]     data_t;

  // One value per instruction class, from the top four bits
  typedef enum logic [3:0] {
    CLS_NOP   = 4'h0,
    CLS_EXT   = 4'h1,
    CLS_BCOND = 4'h2,
    CLS_MOV   = 4'h3,
    CLS_LDSTR = 4'h4,
    CLS_ALU   = 4'h5,
    CLS_SHIFT = 4'h6,
    CLS_RES   = 4'h7,
    CLS_PUPO  = 4'h8,
    CLS_BUCND = 4'h9
  } inst_class_e;

  typedef enum logic [3:0] {
    ALU_AND = 4'h0,
    ALU_OR  = 4'h1,
    ALU_XOR = 4'h2,
    ALU_NOT = 4'h3,
    ALU_NEG = 4'h4,
    ALU_MUL = 4'h5,
    ALU_DIV = 4'h6,
    ALU_REM = 4'h7,
    ALU_ADD = 4'h8,
    ALU_SUB = 4'h9,
    ALU_SEX = 4'hA,
    ALU_ZEX = 4'hB,
    ALU_LSR = 4'hC,
    ALU_LSL = 4'hD,
    ALU_ASR = 4'hE,
    ALU_MOV = 4'hF
  } alu_op_e;

  typedef enum logic {
    OP2_REG = 1'b0,
    OP2_LIT = 1'b1
  } op2_src_e;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU    = 2'd0,
    WB_MEM    = 2'd1,
    WB_BRANCH = 2'd2
  } reg_src_e;

  // Store data source
  typedef enum logic [1:0] {
    MDATA_RN  = 2'd0,
    MDATA_RD  = 2'd1,
    MDATA_ALU = 2'd2,
    MDATA_LIT = 2'd3
  } mem_data_src_e;

  typedef enum logic [1:0] {
    MADDR_ALU = 2'd0,
    MADDR_RN  = 2'd1,
    MADDR_RD  = 2'd2,
    MADDR_LIT = 2'd3
  } mem_addr_src_e;

  typedef struct packed {
    reg_addr_t rd_addr;
    reg_addr_t rn_addr;
    data_t     literal;
  } regfetch_ctrl_t;

  typedef struct packed {
    op2_src_e   op2_src;
    logic       ext_16;
    alu_op_e    opcode;
    logic [3:0] store_flags;
  } alu_ctrl_t;

  typedef struct packed {
    logic       is_branch;
    logic       is_cond;
    logic [2:0] code;
  } branch_ctrl_t;

  typedef struct packed {
    logic          write;
    logic          read;
    logic          is_pop;
    mem_data_src_e data_src;
    mem_addr_src_e addr_src;
  } mem_ctrl_t;

  typedef struct packed {
    logic      write;
    reg_src_e  source;
    reg_addr_t addr;
  } regwb_ctrl_t;

  // Full control bundle handed to the later stages
  typedef struct packed {
    regfetch_ctrl_t regfetch;
    alu_ctrl_t      alu;
    branch_ctrl_t   branch;
    mem_ctrl_t      mem;
    regwb_ctrl_t    regwb;
  } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/decode_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module decode_pipe_reg #(
  parameter type payload_t = logic
)
(
  input  wire           clk,
  input  wire           rst,
  input  wire payload_t in_data,
  input  wire           in_valid,
  output logic          in_ready,
  output payload_t      out_data,
  output logic          out_valid,
  input  wire           out_ready
);

  // Take a new item when empty or when the held one leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_valid <= 1'b0;
    end
    else if (in_ready)
    begin
      // Refill, or drop to empty after an output transfer
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      out_data <= in_data;
    end
  end

  // Payload held while downstream stalls
  a_hold_stable : assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> $stable(out_data)
  );

  // Slot comes out of reset empty
  a_reset_empty : assert property (
    @(posedge clk)
    rst |=> !out_valid
  );

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_cfg.svh"

module inst_decoder
(
  input  wire decode_pkg::inst_t inst,
  output decode_pkg::ctrl_t      ctrl
);

  logic [3:0]              ident;
  decode_pkg::inst_class_e inst_class;
  decode_pkg::op2_src_e    op2_bit12;

  assign ident = inst[`DEC_INST_WIDTH-1 -: 4];

  // Bit 12 gives the operand source directly in MOV, ALU and SHIFT
  assign op2_bit12 = decode_pkg::op2_src_e'(inst[12]);

  always_comb
  begin
    casez (ident)
      4'b0000: inst_class = decode_pkg::CLS_NOP;
      4'b0001: inst_class = decode_pkg::CLS_EXT;
      4'b001?: inst_class = decode_pkg::CLS_BCOND;
      4'b010?: inst_class = decode_pkg::CLS_MOV;
      4'b011?: inst_class = decode_pkg::CLS_LDSTR;
      4'b100?: inst_class = decode_pkg::CLS_ALU;
      4'b101?: inst_class = decode_pkg::CLS_SHIFT;
      4'b110?: inst_class = decode_pkg::CLS_RES;
      4'b1110: inst_class = decode_pkg::CLS_PUPO;
      default: inst_class = decode_pkg::CLS_BUCND;
    endcase
  end

  always_comb
  begin
    // Fields not set below stay zero
    ctrl = '0;
    case (inst_class)
      decode_pkg::CLS_EXT:
      begin
        ctrl.regfetch.rd_addr = inst[7:4];
        ctrl.alu.ext_16       = inst[10];
        ctrl.alu.opcode       = inst[11] ? decode_pkg::ALU_ZEX : decode_pkg::ALU_SEX;
        ctrl.regwb.write      = 1'b1;
        ctrl.regwb.source     = decode_pkg::WB_ALU;
        ctrl.regwb.addr       = inst[7:4];
      end

      decode_pkg::CLS_BCOND:
      begin
        ctrl.regfetch.rn_addr = inst[3:0];
        ctrl.regfetch.literal = {{(`DEC_DATA_WIDTH-8){inst[7]}}, inst[7:0]};
        // Bit 12 set selects the register target
        ctrl.alu.op2_src      = inst[12] ? decode_pkg::OP2_REG : decode_pkg::OP2_LIT;
        ctrl.alu.opcode       = decode_pkg::ALU_MOV;
        ctrl.branch.is_branch = 1'b1;
        ctrl.branch.is_cond   = 1'b1;
        ctrl.branch.code      = inst[10:8];
        // Link variant saves the return address
        ctrl.regwb.write      = inst[11];
        ctrl.regwb.source     = decode_pkg::WB_BRANCH;
        ctrl.regwb.addr       = decode_pkg::reg_addr_t'(`DEC_LINK_REG);
      end

      decode_pkg::CLS_MOV:
      begin
        ctrl.regfetch.rn_addr = inst[3:0];
        ctrl.regfetch.literal = decode_pkg::data_t'(inst[7:0]);
        ctrl.alu.op2_src      = op2_bit12;
        ctrl.alu.opcode       = decode_pkg::ALU_MOV;
        ctrl.regwb.write      = 1'b1;
        ctrl.regwb.source     = decode_pkg::WB_ALU;
        ctrl.regwb.addr       = inst[11:8];
      end

      decode_pkg::CLS_LDSTR:
      begin
        ctrl.regfetch.rd_addr = inst[7:4];
        ctrl.regfetch.rn_addr = inst[11:8];
        ctrl.regfetch.literal = decode_pkg::data_t'(inst[3:0]);
        // Address is base plus offset
        ctrl.alu.op2_src      = decode_pkg::OP2_LIT;
        ctrl.alu.opcode       = decode_pkg::ALU_ADD;
        ctrl.mem.write        = inst[12];
        ctrl.mem.read         = !inst[12];
        ctrl.mem.data_src     = decode_pkg::MDATA_RN;
        ctrl.mem.addr_src     = decode_pkg::MADDR_ALU;
        ctrl.regwb.write      = !inst[12];
        ctrl.regwb.source     = decode_pkg::WB_MEM;
        ctrl.regwb.addr       = inst[11:8];
      end

      decode_pkg::CLS_ALU:
      begin
        ctrl.regfetch.rd_addr = inst[7:4];
        ctrl.regfetch.rn_addr = inst[3:0];
        ctrl.regfetch.literal = decode_pkg::data_t'(inst[3:0]);
        ctrl.alu.op2_src      = op2_bit12;
        ctrl.alu.opcode       = decode_pkg::alu_op_e'(inst[11:8]);
        ctrl.alu.store_flags  = 4'hF;
        ctrl.regwb.write      = 1'b1;
        ctrl.regwb.source     = decode_pkg::WB_ALU;
        ctrl.regwb.addr       = inst[7:4];
      end

      decode_pkg::CLS_SHIFT:
      begin
        ctrl.regfetch.rd_addr = inst[11:8];
        ctrl.regfetch.rn_addr = inst[3:0];
        ctrl.regfetch.literal = decode_pkg::data_t'(inst[4:0]);
        ctrl.alu.op2_src      = op2_bit12;
        // Shift kind offsets from LSR, covering LSR through MOV
        ctrl.alu.opcode       = decode_pkg::alu_op_e'(4'(decode_pkg::ALU_LSR + inst[7:6]));
        ctrl.alu.store_flags  = 4'hF;
        ctrl.regwb.write      = 1'b1;
        ctrl.regwb.source     = decode_pkg::WB_ALU;
        ctrl.regwb.addr       = inst[11:8];
      end

      decode_pkg::CLS_PUPO:
      begin
        ctrl.regfetch.rd_addr = decode_pkg::reg_addr_t'(`DEC_STACK_REG);
        ctrl.regfetch.rn_addr = inst[3:0];
        ctrl.regfetch.literal = decode_pkg::data_t'(`DEC_STACK_STEP);
        ctrl.alu.op2_src      = decode_pkg::OP2_LIT;
        if (!inst[11])
        begin
          // Push: pre-decrement stack pointer, store through it
          ctrl.alu.opcode   = decode_pkg::ALU_SUB;
          ctrl.mem.write    = 1'b1;
          ctrl.mem.addr_src = decode_pkg::MADDR_ALU;
        end
        else
        begin
          // Pop: read at current pointer, then step up
          ctrl.alu.opcode   = decode_pkg::ALU_ADD;
          ctrl.mem.read     = 1'b1;
          ctrl.mem.is_pop   = 1'b1;
          ctrl.mem.addr_src = decode_pkg::MADDR_RN;
          ctrl.regwb.write  = 1'b1;
          ctrl.regwb.source = decode_pkg::WB_MEM;
          ctrl.regwb.addr   = inst[3:0];
        end
      end

      decode_pkg::CLS_BUCND:
      begin
        ctrl.regfetch.rn_addr = inst[3:0];
        ctrl.regfetch.literal = decode_pkg::data_t'(inst[9:0]);
        ctrl.alu.op2_src      = inst[11] ? decode_pkg::OP2_REG : decode_pkg::OP2_LIT;
        ctrl.branch.is_branch = 1'b1;
        ctrl.regwb.write      = inst[10];
        ctrl.regwb.source     = decode_pkg::WB_BRANCH;
        ctrl.regwb.addr       = decode_pkg::reg_addr_t'(`DEC_LINK_REG);
      end

      // NOP and reserved codes decode to an empty bundle
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire decode_pkg::inst_t inst,
  input  wire                    inst_valid,
  output logic                   inst_ready,
  output decode_pkg::ctrl_t      ctrl,
  output logic                   ctrl_valid,
  input  wire                    ctrl_ready
);

  decode_pkg::inst_t slot_inst;
  logic              slot_valid;
  logic              slot_ready;
  decode_pkg::ctrl_t dec_ctrl;

  // Instruction slot, fed from fetch
  decode_pipe_reg #(.payload_t(decode_pkg::inst_t)) u_inst_slot (
    .clk       (clk),
    .rst       (rst),
    .in_data   (inst),
    .in_valid  (inst_valid),
    .in_ready  (inst_ready),
    .out_data  (slot_inst),
    .out_valid (slot_valid),
    .out_ready (slot_ready)
  );

  inst_decoder u_decoder (
    .inst (slot_inst),
    .ctrl (dec_ctrl)
  );

  // Control slot, ready chains back combinationally to the instruction slot
  decode_pipe_reg #(.payload_t(decode_pkg::ctrl_t)) u_ctrl_slot (
    .clk       (clk),
    .rst       (rst),
    .in_data   (dec_ctrl),
    .in_valid  (slot_valid),
    .in_ready  (slot_ready),
    .out_data  (ctrl),
    .out_valid (ctrl_valid),
    .out_ready (ctrl_ready)
  );

endmodule

`default_nettype wire

// File: dv/decode_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_cfg.svh"

module decode_checker
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire decode_pkg::inst_t inst,
  input  wire                    inst_valid,
  input  wire                    inst_ready,
  input  wire decode_pkg::ctrl_t ctrl,
  input  wire                    ctrl_valid,
  input  wire                    ctrl_ready,
  output int                     err_count,
  output int                     cmp_count,
  output int                     pending
);

  decode_pkg::ctrl_t exp_q[$];

  // Expected bundle, built from the instruction format rules
  function automatic decode_pkg::ctrl_t decode_ref(input decode_pkg::inst_t i);
    decode_pkg::ctrl_t    r;
    decode_pkg::op2_src_e sel;
    r = '0;
    // Operand source in MOV, ALU and SHIFT takes the value of bit 12
    sel = i[12] ? decode_pkg::OP2_LIT : decode_pkg::OP2_REG;
    case (i[15:13])
      3'b000:
      begin
        // Only 0001 is EXT, 0000 is NOP
        if (i[12])
        begin
          r.regfetch.rd_addr = i[7:4];
          r.alu.ext_16 = i[10];
          r.alu.opcode = i[11] ? decode_pkg::ALU_ZEX : decode_pkg::ALU_SEX;
          r.regwb = '{1'b1, decode_pkg::WB_ALU, i[7:4]};
        end
      end
      3'b001:
      begin
        r.regfetch = '{4'h0, i[3:0], {{(`DEC_DATA_WIDTH-8){i[7]}}, i[7:0]}};
        r.alu.op2_src = i[12] ? decode_pkg::OP2_REG : decode_pkg::OP2_LIT;
        r.alu.opcode = decode_pkg::ALU_MOV;
        r.branch = '{1'b1, 1'b1, i[10:8]};
        r.regwb = '{i[11], decode_pkg::WB_BRANCH, 4'(`DEC_LINK_REG)};
      end
      3'b010:
      begin
        r.regfetch = '{4'h0, i[3:0], decode_pkg::data_t'(i[7:0])};
        r.alu.op2_src = sel;
        r.alu.opcode = decode_pkg::ALU_MOV;
        r.regwb = '{1'b1, decode_pkg::WB_ALU, i[11:8]};
      end
      3'b011:
      begin
        r.regfetch = '{i[7:4], i[11:8], decode_pkg::data_t'(i[3:0])};
        r.alu.op2_src = decode_pkg::OP2_LIT;
        r.alu.opcode = decode_pkg::ALU_ADD;
        r.mem = '{i[12], !i[12], 1'b0, decode_pkg::MDATA_RN, decode_pkg::MADDR_ALU};
        r.regwb = '{!i[12], decode_pkg::WB_MEM, i[11:8]};
      end
      3'b100:
      begin
        r.regfetch = '{i[7:4], i[3:0], decode_pkg::data_t'(i[3:0])};
        r.alu = '{sel, 1'b0, decode_pkg::alu_op_e'(i[11:8]), 4'hF};
        r.regwb = '{1'b1, decode_pkg::WB_ALU, i[7:4]};
      end
      3'b101:
      begin
        r.regfetch = '{i[11:8], i[3:0], decode_pkg::data_t'(i[4:0])};
        r.alu = '{sel, 1'b0, decode_pkg::ALU_LSR, 4'hF};
        case (i[7:6])
          2'd0: r.alu.opcode = decode_pkg::ALU_LSR;
          2'd1: r.alu.opcode = decode_pkg::ALU_LSL;
          2'd2: r.alu.opcode = decode_pkg::ALU_ASR;
          default: r.alu.opcode = decode_pkg::ALU_MOV;
        endcase
        r.regwb = '{1'b1, decode_pkg::WB_ALU, i[11:8]};
      end
      3'b111:
      begin
        if (!i[12])
        begin
          r.regfetch = '{4'(`DEC_STACK_REG), i[3:0], decode_pkg::data_t'(`DEC_STACK_STEP)};
          r.alu.op2_src = decode_pkg::OP2_LIT;
          if (i[11])
          begin
            r.alu.opcode = decode_pkg::ALU_ADD;
            r.mem = '{1'b0, 1'b1, 1'b1, decode_pkg::MDATA_RN, decode_pkg::MADDR_RN};
            r.regwb = '{1'b1, decode_pkg::WB_MEM, i[3:0]};
          end
          else
          begin
            r.alu.opcode = decode_pkg::ALU_SUB;
            r.mem = '{1'b1, 1'b0, 1'b0, decode_pkg::MDATA_RN, decode_pkg::MADDR_ALU};
          end
        end
        else
        begin
          r.regfetch = '{4'h0, i[3:0], decode_pkg::data_t'(i[9:0])};
          r.alu.op2_src = i[11] ? decode_pkg::OP2_REG : decode_pkg::OP2_LIT;
          r.branch.is_branch = 1'b1;
          r.regwb = '{i[10], decode_pkg::WB_BRANCH, 4'(`DEC_LINK_REG)};
        end
      end
      default:
      begin
        // Reserved codes give an empty bundle
        r = '0;
      end
    endcase
    return r;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
      err_count++;
    end
  endtask

  task automatic compare_bundle(input decode_pkg::ctrl_t e, input decode_pkg::ctrl_t a);
    check_field("regfetch.rd_addr", 32'(e.regfetch.rd_addr), 32'(a.regfetch.rd_addr));
    check_field("regfetch.rn_addr", 32'(e.regfetch.rn_addr), 32'(a.regfetch.rn_addr));
    check_field("regfetch.literal", 32'(e.regfetch.literal), 32'(a.regfetch.literal));
    check_field("alu.op2_src", 32'(e.alu.op2_src), 32'(a.alu.op2_src));
    check_field("alu.ext_16", 32'(e.alu.ext_16), 32'(a.alu.ext_16));
    check_field("alu.opcode", 32'(e.alu.opcode), 32'(a.alu.opcode));
    check_field("alu.store_flags", 32'(e.alu.store_flags), 32'(a.alu.store_flags));
    check_field("branch.is_branch", 32'(e.branch.is_branch), 32'(a.branch.is_branch));
    check_field("branch.is_cond", 32'(e.branch.is_cond), 32'(a.branch.is_cond));
    check_field("branch.code", 32'(e.branch.code), 32'(a.branch.code));
    check_field("mem.write", 32'(e.mem.write), 32'(a.mem.write));
    check_field("mem.read", 32'(e.mem.read), 32'(a.mem.read));
    check_field("mem.is_pop", 32'(e.mem.is_pop), 32'(a.mem.is_pop));
    check_field("mem.data_src", 32'(e.mem.data_src), 32'(a.mem.data_src));
    check_field("mem.addr_src", 32'(e.mem.addr_src), 32'(a.mem.addr_src));
    check_field("regwb.write", 32'(e.regwb.write), 32'(a.regwb.write));
    check_field("regwb.source", 32'(e.regwb.source), 32'(a.regwb.source));
    check_field("regwb.addr", 32'(e.regwb.addr), 32'(a.regwb.addr));
  endtask

  // Pop before push, a new instruction cannot leave in its own cycle
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (ctrl_valid && ctrl_ready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Error at %0t: bundle left the stage with nothing outstanding", $time);
          err_count++;
        end
        else
        begin
          compare_bundle(exp_q.pop_front(), ctrl);
          cmp_count++;
        end
      end
      if (inst_valid && inst_ready)
        exp_q.push_back(decode_ref(inst));
      if (!inst_ready && !(ctrl_valid && !ctrl_ready))
      begin
        $display("Error at %0t: inst_ready low while the output is not stalled", $time);
        err_count++;
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// File: dv/decode_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_cfg.svh"

module decode_stage_tb;

  localparam int STREAM_LEN     = 200;
  localparam int N_DIRECTED     = 21;
  localparam int STIM_CYCLES    = 5 + N_DIRECTED + 2 * STREAM_LEN;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  // One or more per class and per source or type bit
  localparam logic [`DEC_INST_WIDTH-1:0] DIRECTED [N_DIRECTED] = '{
    16'h0000, 16'h1A35, 16'h1435, 16'h2D85, 16'h3312, 16'h47A3, 16'h5C04,
    16'h6A5F, 16'h7A5F, 16'h8934, 16'h9234, 16'hA51F, 16'hB55F, 16'hA59F,
    16'hB5DF, 16'hC123, 16'hDFFF, 16'hE007, 16'hE807, 16'hF3FF, 16'hFC21
  };

  logic              clk = 1'b0;
  logic              rst;
  decode_pkg::inst_t inst;
  logic              inst_valid;
  logic              inst_ready;
  decode_pkg::ctrl_t ctrl;
  logic              ctrl_valid;
  logic              ctrl_ready;
  logic              ready_random;
  bit                ready_bit;
  bit                ready_pat [1024];
  logic [9:0]        ready_idx = '0;
  decode_pkg::inst_t stream [STREAM_LEN];
  int                seed;
  int                tb_errors;
  int                gap_errors;
  int                out_count;
  int                gap_base;
  bit                gap_watch;
  bit                gap_started;
  bit                saw_stall;
  int                cycle_count;
  int                err_count;
  int                cmp_count;
  int                pending;

  always #20 clk = ~clk;

  decode_stage DUT (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid),
    .ctrl_ready (ctrl_ready)
  );

  decode_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid),
    .ctrl_ready (ctrl_ready),
    .err_count  (err_count),
    .cmp_count  (cmp_count),
    .pending    (pending)
  );

  // Downstream ready, random only in the back-pressure test
  assign ctrl_ready = ready_random ? ready_bit : 1'b1;

  always @(negedge clk)
  begin
    ready_bit = ready_pat[ready_idx];
    ready_idx = ready_idx + 10'd1;
  end

  always @(posedge clk)
  begin
    if (ctrl_valid && ctrl_ready)
      out_count <= out_count + 1;
    if (!gap_watch)
      gap_started <= 1'b0;
    else if (ctrl_valid)
      gap_started <= 1'b1;
    else if (gap_started && out_count < gap_base + STREAM_LEN)
    begin
      $display("Error at %0t: ctrl_valid dropped in the middle of the stream", $time);
      gap_errors <= gap_errors + 1;
    end
    if (ready_random && !inst_ready)
      saw_stall <= 1'b1;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic int total_errors();
    return tb_errors + gap_errors + err_count;
  endfunction

  task automatic send_inst(input decode_pkg::inst_t value);
    @(negedge clk);
    inst = value;
    inst_valid = 1'b1;
    @(posedge clk);
    while (!inst_ready)
      @(posedge clk);
  endtask

  task automatic go_idle();
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic drain();
    while (pending != 0)
      @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (total_errors() == errs_before)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d errors", name, total_errors() - errs_before);
  endtask

  initial
  begin
    int r;
    int e;
    seed = 17;
    rst = 1'b1;
    inst = '0;
    inst_valid = 1'b0;
    ready_random = 1'b0;
    for (int k = 0; k < STREAM_LEN; k++)
    begin
      r = $random(seed);
      stream[k] = r[15:0];
    end
    for (int k = 0; k < 1024; k++)
    begin
      r = $random(seed);
      ready_pat[k] = r[0];
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    e = total_errors();
    @(negedge clk);
    if (ctrl_valid !== 1'b0 || inst_ready !== 1'b1)
    begin
      $display("Error at %0t: after reset ctrl_valid is not low or inst_ready is not high", $time);
      tb_errors++;
    end
    report_test("reset", e);

    e = total_errors();
    for (int k = 0; k < N_DIRECTED; k++)
      send_inst(DIRECTED[k]);
    go_idle();
    drain();
    report_test("directed", e);

    e = total_errors();
    gap_base = out_count;
    gap_watch = 1'b1;
    for (int k = 0; k < STREAM_LEN; k++)
      send_inst(stream[k]);
    go_idle();
    drain();
    gap_watch = 1'b0;
    report_test("stream", e);

    e = total_errors();
    ready_random = 1'b1;
    for (int k = 0; k < STREAM_LEN; k++)
      send_inst(stream[k]);
    go_idle();
    drain();
    ready_random = 1'b0;
    if (!saw_stall)
    begin
      $display("Error at %0t: inst_ready never fell under back-pressure", $time);
      tb_errors++;
    end
    report_test("backpressure", e);

    // Let the pipe settle, then every accepted instruction must have one bundle
    e = total_errors();
    repeat (4) @(negedge clk);
    if (pending != 0 || cmp_count != N_DIRECTED + 2 * STREAM_LEN)
    begin
      $display("Error at %0t: %0d bundles out, %0d still expected", $time, cmp_count, pending);
      tb_errors++;
    end
    report_test("drain", e);

    $display("Summary: %0d bundles compared, %0d errors", cmp_count, total_errors());
    if (total_errors() == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/decode_pkg.sv
hdl/decode_pipe_reg.sv
hdl/inst_decoder.sv
hdl/decode_stage.sv
dv/decode_checker.sv
dv/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = decode_stage_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
